// File: sources.f
+incdir+rtl
rtl/hd44780_pkg.sv
rtl/lcd_nybble_sender.sv
rtl/lcd_byte_sender.sv
rtl/lcd_test_sequencer.sv
rtl/alive_blinker.sv
rtl/hd44780_top.sv
sim/hd44780_properties.sv
sim/tb_hd44780.sv

// File: Makefile
# Verilator build and run for the hd44780 bring-up testbench
# override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= tb_hd44780
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= NO ERRORS
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/tb_hd44780.sv
// ************************************************************
// directed testbench for the hd44780 bring-up top level
// runs idle, arming, test byte, lockup, rgb and led checks in
// order, one report line per test and a closing summary
// ************************************************************
`timescale 1ns/1ps
`include "hd44780_defines.svh"

module tb_hd44780;

    localparam int         PWEH      = `H4_TICKS_PWEH;
    localparam int         TCYCE     = `H4_TICKS_TCYCE;
    localparam int         PERIOD    = 1 << `H4_BLINK_BITS;        // blink period
    localparam int         DUTY      = (PERIOD / 2) / (1 << `H4_PWM_BITS);
    localparam logic [7:0] TEST_BYTE = `H4_TEST_BYTE;
    localparam logic       TEST_RS   = `H4_TEST_RS;

    logic                   clk;
    logic                   rst_n;
    logic                   button_n;
    logic                   la_strobe;
    logic [3:0]             led_n;
    hd44780_pkg::lcd_pins_t lcd;
    hd44780_pkg::rgb_t      rgb;

    int    errors = 0;
    int    tests  = 0;
    string cur_test;

    // E pulse log, taken from pre-edge values on each rising edge
    int                     n_pulses = 0;
    int                     cycle    = 0;
    logic                   e_prev   = 1'b0;
    int                     rise_at [4];
    int                     width   [4];
    hd44780_pkg::lcd_pins_t pins_at [4];

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                 // 20 ns period
    end

    hd44780_top i_dut (
        .clk         (clk),
        .i_rst_n     (rst_n),
        .i_button_n  (button_n),
        .o_lcd       (lcd),
        .o_rgb       (rgb),
        .o_led_n     (led_n),
        .o_la_strobe (la_strobe)
    );

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (lcd.e && n_pulses < 4) begin
            if (!e_prev) begin                  // rising E, grab pins once
                rise_at[n_pulses] = cycle;
                pins_at[n_pulses] = lcd;
                width[n_pulses]   = 0;
            end
            width[n_pulses] = width[n_pulses] + 1;
        end else if (!lcd.e && e_prev) begin
            n_pulses = n_pulses + 1;            // pulse complete on the fall
        end
        e_prev = lcd.e;
    end

    // ************************************************************
    // compare and report helpers
    // ************************************************************
    task automatic compare_lcd(input string what, input hd44780_pkg::lcd_pins_t exp,
                               input hd44780_pkg::lcd_pins_t act);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s %s expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic compare_rgb(input string what, input hd44780_pkg::rgb_t exp,
                               input hd44780_pkg::rgb_t act);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s %s expected %b actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic compare_leds(input string what, input logic [3:0] exp,
                                input logic [3:0] act);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s %s expected %b actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic compare_count(input string what, input int exp, input int act);
        if (act != exp) begin
            errors++;
            $display("MISMATCH %s %s expected %0d actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("test %s failed: %s", cur_test, msg);
    endtask

    task automatic end_test(input int err0);
        tests++;
        $display("test %s finished with %0d errors", cur_test, errors - err0);
    endtask

    // ************************************************************
    // directed tests
    // ************************************************************
    task automatic test_idle();
        int         err0;
        int         strobe_cycles;
        int         e_cycles;
        logic [3:0] led_and;                    // any led that lit shows a 0 here
        err0          = errors;
        cur_test      = "idle";
        strobe_cycles = 0;
        e_cycles      = 0;
        led_and       = 4'hf;
        @(negedge clk);
        compare_rgb("rgb after reset", '0, rgb);
        repeat (300) begin
            @(negedge clk);
            if (la_strobe) strobe_cycles++;
            if (lcd.e) e_cycles++;
            led_and = led_and & led_n;
        end
        compare_count("la_strobe high cycles", 0, strobe_cycles);
        compare_count("E high cycles", 0, e_cycles);
        compare_lcd("lcd pins", '0, lcd);
        compare_leds("leds over idle window", 4'hf, led_and);
        end_test(err0);
    endtask

    task automatic test_arming();
        int err0;
        int waited;
        int low_cycles;
        err0       = errors;
        cur_test   = "arming";
        low_cycles = 0;
        @(posedge clk);
        button_n <= 1'b0;
        @(posedge clk);
        button_n <= 1'b1;                       // one-cycle press
        waited = 1;
        @(negedge clk);
        while (!la_strobe && waited < 3) begin
            @(negedge clk);
            waited++;
        end
        if (!la_strobe) report_failure("la_strobe did not rise within 3 cycles of the press");
        repeat (200) begin
            @(negedge clk);
            if (!la_strobe) low_cycles++;
        end
        compare_count("la_strobe low cycles after release", 0, low_cycles);
        end_test(err0);
    endtask

    task automatic test_byte();
        int                     err0;
        int                     waited;
        hd44780_pkg::lcd_pins_t exp;
        err0     = errors;
        cur_test = "test_byte";
        waited   = 0;
        while (n_pulses < 2 && waited < 1000) begin
            @(negedge clk);
            waited++;
        end
        if (n_pulses < 2) begin
            report_failure("fewer than two E pulses arrived before the timeout");
        end else begin
            exp.rs   = TEST_RS;
            exp.e    = 1'b1;
            exp.data = TEST_BYTE[7:4];          // high nybble goes first
            compare_lcd("first pulse pins", exp, pins_at[0]);
            exp.data = TEST_BYTE[3:0];
            compare_lcd("second pulse pins", exp, pins_at[1]);
            compare_count("first pulse width", PWEH, width[0]);
            compare_count("second pulse width", PWEH, width[1]);
            if (rise_at[1] - rise_at[0] < TCYCE)
                report_failure("E pulses are closer together than the cycle time");
        end
        compare_count("E pulses", 2, n_pulses);
        end_test(err0);
    endtask

    task automatic test_lockup();
        int err0;
        int e_cycles;
        err0     = errors;
        cur_test = "lockup";
        e_cycles = 0;
        repeat (2000) begin
            @(negedge clk);
            if (lcd.e) e_cycles++;
        end
        compare_count("E high cycles after the byte", 0, e_cycles);
        compare_count("E pulses", 2, n_pulses);
        end_test(err0);
    endtask

    task automatic test_rgb_duty();
        int err0;
        int g_cnt;
        int b_cnt;
        int r_cnt;
        int gb_cnt;                             // green and blue lit in the same cycle
        err0     = errors;
        cur_test = "rgb_duty";
        g_cnt    = 0;
        b_cnt    = 0;
        r_cnt    = 0;
        gb_cnt   = 0;
        repeat (PERIOD) begin
            @(negedge clk);
            if (rgb.g) g_cnt++;
            if (rgb.b) b_cnt++;
            if (rgb.r) r_cnt++;
            if (rgb.g && rgb.b) gb_cnt++;       // opposite halves of the period
        end
        compare_count("green lit cycles", DUTY, g_cnt);
        compare_count("blue lit cycles", DUTY, b_cnt);
        compare_count("red lit cycles", DUTY, r_cnt);
        compare_count("green and blue lit together", 0, gb_cnt);
        end_test(err0);
    endtask

    task automatic test_leds();
        int err0;
        int low_cnt [4];
        err0     = errors;
        cur_test = "leds_armed";
        for (int i = 0; i < 4; i++) begin
            low_cnt[i] = 0;
        end
        repeat (PERIOD) begin
            @(negedge clk);
            for (int i = 0; i < 4; i++) begin
                if (!led_n[i]) low_cnt[i]++;    // active low, lit
            end
        end
        for (int i = 0; i < 4; i++) begin
            compare_count($sformatf("led %0d lit cycles", i), PERIOD / 2, low_cnt[i]);
        end
        end_test(err0);
    endtask

    // ************************************************************
    // sequence and summary
    // ************************************************************
    initial begin
        rst_n    <= 1'b0;
        button_n <= 1'b1;                       // button released
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        test_idle();
        test_arming();
        test_byte();
        test_lockup();
        test_rgb_duty();
        test_leds();
        if (i_dut.u_byte.u_nybble.u_props.fail_count != 0) begin
            errors = errors + i_dut.u_byte.u_nybble.u_props.fail_count;
            $display("nybble sender pin assertions failed %0d times",
                     i_dut.u_byte.u_nybble.u_props.fail_count);
        end
        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: sim/hd44780_properties.sv
// ************************************************************
// concurrent checks on the nybble sender's lcd pin timing
// bound into every lcd_nybble_sender instance by the bind below
// ************************************************************
`timescale 1ns/1ps
`include "hd44780_defines.svh"

module hd44780_properties (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_busy,      // sender busy
    input  hd44780_pkg::lcd_pins_t i_lcd        // sender pins
);

    localparam int PWEH = `H4_TICKS_PWEH;

    int e_width;                                // cycles E has been high so far
    int fail_count = 0;                         // failed assertions so far

    always_ff @(posedge clk) begin
        if (!i_rst_n) e_width <= 0;
        else if (i_lcd.e) e_width <= e_width + 1;
        else e_width <= 0;
    end

    // E only inside a busy window
    a_e_in_busy: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_lcd.e |-> i_busy)
        else begin
            $error("E high while the nybble sender is idle");
            fail_count++;
        end

    // lcd samples rs and data on the E fall, so both hold across the pulse
    a_pins_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_lcd.e && $past(i_lcd.e)) |-> $stable({i_lcd.rs, i_lcd.data}))
        else begin
            $error("rs or data changed while E was high");
            fail_count++;
        end

    a_e_width: assert property (@(posedge clk) disable iff (!i_rst_n)
        $fell(i_lcd.e) |-> (e_width == PWEH))
        else begin
            $error("E pulse width differs from the enable width count");
            fail_count++;
        end

endmodule

bind lcd_nybble_sender hd44780_properties u_props (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_busy  (o_busy),
    .i_lcd   (o_lcd)
);

// File: rtl/hd44780_top.sv
// ************************************************************
// top level of the hd44780 4-bit bring-up design
// the sequencer arms on the button and feeds one test byte to
// the byte sender, the blinker runs beside it on its own pins
// ************************************************************
`timescale 1ns/1ps

module hd44780_top (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_button_n,  // active low
    output hd44780_pkg::lcd_pins_t o_lcd,       // rs, e, db7..db4
    output hd44780_pkg::rgb_t      o_rgb,       // dimmed on-board rgb
    output logic [3:0]             o_led_n,     // external leds, active low
    output logic                   o_la_strobe  // logic analyzer trigger
);

    logic       armed;
    logic       byte_stb;
    logic [7:0] byte_data;
    logic       byte_rs;
    logic       byte_busy;

    // ************************************************************
    // lcd path
    // ************************************************************
    lcd_test_sequencer u_seq (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_button_n  (i_button_n),
        .i_busy      (byte_busy),
        .o_armed     (armed),
        .o_la_strobe (o_la_strobe),
        .o_stb       (byte_stb),
        .o_byte      (byte_data),
        .o_rs        (byte_rs)
    );

    lcd_byte_sender u_byte (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_stb   (byte_stb),
        .i_rs    (byte_rs),
        .i_byte  (byte_data),
        .o_busy  (byte_busy),
        .o_lcd   (o_lcd)
    );

    // ************************************************************
    // alive indicators
    // ************************************************************
    alive_blinker u_blink (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_armed (armed),           // external leds wait for the press
        .o_rgb   (o_rgb),
        .o_led_n (o_led_n)
    );

endmodule

// File: rtl/alive_blinker.sv
// ************************************************************
// alive indicator, runs from reset regardless of the lcd path
// rgb outputs follow the blink counter's top bits, dimmed by a
// 1-in-8 pwm gate, the four external leds (active low) stay
// dark until i_armed and then blink off the same counter
// ************************************************************
`timescale 1ns/1ps
`include "hd44780_defines.svh"

module alive_blinker (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_armed,      // from the test sequencer
    output hd44780_pkg::rgb_t o_rgb,        // active high
    output logic [3:0]        o_led_n       // active low
);

    localparam int BW = `H4_BLINK_BITS;
    localparam int PW = `H4_PWM_BITS;

    logic [BW-1:0] blink_cnt;
    logic [PW-1:0] pwm_cnt;
    logic          pwm_on;                  // one cycle in 2**PW

    assign pwm_on = &pwm_cnt;

    // ************************************************************
    // free-running counters
    // ************************************************************
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            blink_cnt <= '0;
            pwm_cnt   <= '0;
        end else begin
            blink_cnt <= blink_cnt + 1'b1;
            pwm_cnt   <= pwm_cnt + 1'b1;
        end
    end

    // registered outputs, one cycle behind the counters
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_rgb   <= '0;
            o_led_n <= '1;                          // all dark
        end else begin
            o_rgb.g <= pwm_on & ~blink_cnt[BW-1];
            o_rgb.b <= pwm_on &  blink_cnt[BW-1];
            o_rgb.r <= pwm_on & ~blink_cnt[BW-2];
            if (i_armed) begin
                o_led_n[0] <=  blink_cnt[BW-2];
                o_led_n[1] <= ~blink_cnt[BW-3];
                o_led_n[2] <=  blink_cnt[BW-3];
                o_led_n[3] <= ~blink_cnt[BW-4];
            end else begin
                o_led_n <= '1;                      // held off until armed
            end
        end
    end

endmodule

// File: rtl/lcd_test_sequencer.sv
// ************************************************************
// one-shot test driver for the byte sender
// the first button press arms the design and raises the
// logic-analyzer strobe, then the test byte goes out once
// and the FSM locks up until reset
// ************************************************************
`timescale 1ns/1ps
`include "hd44780_defines.svh"

module lcd_test_sequencer (
    input  logic       clk,
    input  logic       i_rst_n,
    input  logic       i_button_n,      // raw button, active low, no debounce
    input  logic       i_busy,          // byte sender busy
    output logic       o_armed,         // button has been pressed
    output logic       o_la_strobe,     // analyzer trigger, stays high
    output logic       o_stb,           // one-cycle byte send strobe
    output logic [7:0] o_byte,
    output logic       o_rs
);

    hd44780_pkg::seq_state_e state;
    logic                    seen_busy;     // busy has risen since the strobe

    // arm latch, a bouncy press only sets it harder
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_armed     <= 1'b0;
            o_la_strobe <= 1'b0;
        end else if (!o_armed && !i_button_n) begin
            o_armed     <= 1'b1;
            o_la_strobe <= 1'b1;
        end
    end

    // ************************************************************
    // send-once FSM, held in idle until armed
    // ************************************************************
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state     <= hd44780_pkg::SEQ_IDLE;
            o_stb     <= 1'b0;
            seen_busy <= 1'b0;
        end else if (o_armed) begin
            case (state)
                hd44780_pkg::SEQ_IDLE: state <= hd44780_pkg::SEQ_LOAD;
                hd44780_pkg::SEQ_LOAD: begin
                    o_stb     <= 1'b1;
                    seen_busy <= 1'b0;
                    state     <= hd44780_pkg::SEQ_WAIT_END;
                end
                hd44780_pkg::SEQ_WAIT_END: begin
                    o_stb <= 1'b0;
                    if (i_busy) seen_busy <= 1'b1;          // skip the stale low
                    else if (seen_busy) state <= hd44780_pkg::SEQ_LOCKUP;
                end
                hd44780_pkg::SEQ_LOCKUP: o_stb <= 1'b0;     // parked for good
                default: begin
                    o_stb <= 1'b0;
                    state <= hd44780_pkg::SEQ_LOCKUP;
                end
            endcase
        end
    end

    // byte and rs set up together with the strobe
    always_ff @(posedge clk) begin
        if (o_armed && (state == hd44780_pkg::SEQ_LOAD)) begin
            o_byte <= `H4_TEST_BYTE;
            o_rs   <= `H4_TEST_RS;
        end
    end

endmodule

// File: rtl/lcd_byte_sender.sv
// ************************************************************
// sends a full byte over the 4-bit bus as two nybbles
// high nybble first, then low, each through the nybble sender
// pulse i_stb for one cycle while o_busy is low, o_busy covers
// both nybbles and falls after the low nybble's cycle time
// ************************************************************
`timescale 1ns/1ps

module lcd_byte_sender (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_stb,       // one-cycle send request
    input  logic                   i_rs,        // rs for both nybbles
    input  logic [7:0]             i_byte,
    output logic                   o_busy,
    output hd44780_pkg::lcd_pins_t o_lcd
);

    hd44780_pkg::byte_state_e state;
    logic [7:0]               byte_q;           // byte held for both halves
    logic                     rs_q;

    logic                     nyb_stb;
    logic [3:0]               nyb_data;
    logic                     nyb_busy;

    // strobe straight from the state so nybble busy is valid
    // on the very next cycle in the wait states
    assign nyb_stb  = (state == hd44780_pkg::BYTE_HIGH) ||
                      (state == hd44780_pkg::BYTE_LOW);
    assign nyb_data = (state == hd44780_pkg::BYTE_LOW) ? byte_q[3:0] : byte_q[7:4];
    assign o_busy   = (state != hd44780_pkg::BYTE_IDLE);

    // ************************************************************
    // two-nybble sequence
    // ************************************************************
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state <= hd44780_pkg::BYTE_IDLE;
        end else begin
            case (state)
                hd44780_pkg::BYTE_IDLE: begin
                    if (i_stb) state <= hd44780_pkg::BYTE_HIGH;
                end
                hd44780_pkg::BYTE_HIGH:                 // nybble sender accepts here
                    state <= hd44780_pkg::BYTE_WAIT_HIGH;
                hd44780_pkg::BYTE_WAIT_HIGH: begin
                    if (!nyb_busy) state <= hd44780_pkg::BYTE_LOW;
                end
                hd44780_pkg::BYTE_LOW:
                    state <= hd44780_pkg::BYTE_WAIT_LOW;
                hd44780_pkg::BYTE_WAIT_LOW: begin       // done once tcycE is over
                    if (!nyb_busy) state <= hd44780_pkg::BYTE_IDLE;
                end
                default: state <= hd44780_pkg::BYTE_IDLE;
            endcase
        end
    end

    // payload capture on an accepted strobe
    always_ff @(posedge clk) begin
        if ((state == hd44780_pkg::BYTE_IDLE) && i_stb) begin
            byte_q <= i_byte;
            rs_q   <= i_rs;
        end
    end

    lcd_nybble_sender u_nybble (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_stb    (nyb_stb),
        .i_rs     (rs_q),
        .i_nybble (nyb_data),
        .o_busy   (nyb_busy),
        .o_lcd    (o_lcd)
    );

endmodule

// File: rtl/lcd_nybble_sender.sv
// ************************************************************
// puts one nybble on the hd44780 4-bit bus
// pulse i_stb for one cycle while o_busy is low, rs and data
// are latched onto the pins, E pulses after the setup time and
// o_busy drops once the full enable cycle time has passed
// ************************************************************
`timescale 1ns/1ps
`include "hd44780_defines.svh"

module lcd_nybble_sender (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_stb,       // one-cycle send request
    input  logic                   i_rs,        // register select for this nybble
    input  logic [3:0]             i_nybble,    // goes to db7..db4
    output logic                   o_busy,      // high from accept until tcyce done
    output hd44780_pkg::lcd_pins_t o_lcd        // pins, held stable while busy
);

    localparam int CW = `H4_COUNT_BITS;

    // counter reload values, each phase counts down to zero
    localparam logic [CW-1:0] TAS_LOAD  = CW'(`H4_TICKS_TAS - 1);
    localparam logic [CW-1:0] PWEH_LOAD = CW'(`H4_TICKS_PWEH - 1);
    localparam logic [CW-1:0] HOLD_LOAD = CW'(`H4_TICKS_TCYCE - `H4_TICKS_PWEH - 1);

    hd44780_pkg::nyb_state_e state;
    logic [CW-1:0]           cnt;               // shared phase timer

    // ************************************************************
    // setup, enable pulse and cycle hold
    // ************************************************************
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state  <= hd44780_pkg::NYB_IDLE;
            cnt    <= '0;
            o_busy <= 1'b0;
            o_lcd  <= '0;                       // pins low out of reset
        end else begin
            case (state)
                hd44780_pkg::NYB_IDLE: begin
                    if (i_stb) begin
                        o_lcd.rs   <= i_rs;     // rs and data go out first
                        o_lcd.data <= i_nybble;
                        o_busy     <= 1'b1;
                        cnt        <= TAS_LOAD;
                        state      <= hd44780_pkg::NYB_SETUP;
                    end
                end
                hd44780_pkg::NYB_SETUP: begin   // address setup, tAS
                    if (cnt == '0) begin
                        o_lcd.e <= 1'b1;
                        cnt     <= PWEH_LOAD;
                        state   <= hd44780_pkg::NYB_PULSE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                hd44780_pkg::NYB_PULSE: begin   // enable high, PWEH
                    if (cnt == '0) begin
                        o_lcd.e <= 1'b0;        // lcd samples on this fall
                        cnt     <= HOLD_LOAD;
                        state   <= hd44780_pkg::NYB_HOLD;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                hd44780_pkg::NYB_HOLD: begin    // rest of tcycE, pins held
                    if (cnt == '0) begin
                        o_busy <= 1'b0;
                        state  <= hd44780_pkg::NYB_IDLE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: begin
                    o_lcd.e <= 1'b0;
                    o_busy  <= 1'b0;
                    state   <= hd44780_pkg::NYB_IDLE;
                end
            endcase
        end
    end

endmodule

// File: rtl/hd44780_pkg.sv
// ************************************************************
// shared types for the hd44780 bring-up design
// pin groups travel as packed structs, FSM states as enums
// reference by scoped name, hd44780_pkg::lcd_pins_t etc
// ************************************************************

package hd44780_pkg;

    // lcd pins as they leave the chip, r/w is tied low on the board
    typedef struct packed {
        logic       rs;         // register select
        logic       e;          // enable strobe
        logic [3:0] data;       // db7..db4
    } lcd_pins_t;

    // on-board rgb, ordering follows the driver channels 0..2
    typedef struct packed {
        logic g;
        logic b;
        logic r;
    } rgb_t;

    // nybble sender states
    typedef enum logic [1:0] {
        NYB_IDLE, NYB_SETUP, NYB_PULSE, NYB_HOLD
    } nyb_state_e;

    // byte sender states
    typedef enum logic [2:0] {
        BYTE_IDLE, BYTE_HIGH, BYTE_WAIT_HIGH, BYTE_LOW, BYTE_WAIT_LOW
    } byte_state_e;

    // test sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE, SEQ_LOAD, SEQ_WAIT_END, SEQ_LOCKUP
    } seq_state_e;

endpackage

// File: rtl/hd44780_defines.svh
// ************************************************************
// timing counts, blink widths and the test byte for the
// hd44780 4-bit bring-up design
// all delays are in clk cycles and sized for simulation
// include wherever a count or the test byte is needed
// ************************************************************

`ifndef HD44780_DEFINES_SVH
`define HD44780_DEFINES_SVH

// ************************************************************
// nybble sender timing
// ************************************************************
`define H4_TICKS_TAS    (2)     // nybble latch to E rise
`define H4_TICKS_PWEH   (4)     // E high width
`define H4_TICKS_TCYCE  (10)    // E rise to next nybble, must exceed PWEH
`define H4_COUNT_BITS   (6)     // width of the sender down-counter

// ************************************************************
// alive blinker
// ************************************************************
`define H4_BLINK_BITS   (8)     // blink period is 2**BLINK_BITS cycles
`define H4_PWM_BITS     (3)     // rgb lit 1 cycle in 2**PWM_BITS

// ************************************************************
// test sequence payload
// ************************************************************
`define H4_TEST_BYTE    (8'h47)
`define H4_TEST_RS      (1'b0)  // 0 selects the command register

`endif
